//--- logic/corr_macros.svh
`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// Counter and window sizing
`define CORR_CNT_W        16
`define CORR_WINDOW_LEN   1000  // Samples per window, fits in CORR_CNT_W

// Probe synchronizer depth
`define CORR_SYNC_STAGES  2

// LED PWM counter and duty width
`define CORR_PWM_W        8

// Host command bytes
`define CORR_CMD_START    8'h53  // 'S'
`define CORR_CMD_READ     8'h52  // 'R'
`define CORR_CMD_LED      8'h4C  // 'L', next byte is duty

`endif

//--- logic/corr_pkg.sv
`include "corr_macros.svh"

package corr_pkg;

  // One window result, cnt_x in the top bits
  typedef struct packed {
    logic [`CORR_CNT_W-1:0] cnt_x;   // Samples with X high
    logic [`CORR_CNT_W-1:0] cnt_y;   // Samples with Y high
    logic [`CORR_CNT_W-1:0] cnt_xy;  // Samples with both high
  } corr_counts_t;

  // One beat on the byte pipe, ready travels separately
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
  } bp_beat_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,      // Waiting for a command byte
    GET_DUTY,  // Next byte is the LED duty
    WAIT_SER   // Readout streaming, input held off
  } corr_state_e;

endpackage

//--- logic/corr_accum.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_accum import corr_pkg::*; (
  input  logic         i_clk_48MHz,
  input  logic         i_rst,
  input  logic         i_x,
  input  logic         i_y,
  input  logic         i_start,
  output logic         o_done,
  output corr_counts_t o_counts
);

  localparam int SYNC_N = `CORR_SYNC_STAGES;
  localparam int CNT_W  = `CORR_CNT_W;
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`CORR_WINDOW_LEN - 1);

  logic [SYNC_N-1:0] x_sync;
  logic [SYNC_N-1:0] y_sync;
  logic              x_s;
  logic              y_s;
  logic              running_q;
  logic              done_q;
  logic [CNT_W-1:0]  idx_q;     // Sample index within window
  corr_counts_t      cnt_q;
  corr_counts_t      cnt_d;
  corr_counts_t      result_q;  // Held from done to next done

  // Probe synchronizers
  always_ff @(posedge i_clk_48MHz) begin
    x_sync <= {x_sync[SYNC_N-2:0], i_x};
    y_sync <= {y_sync[SYNC_N-2:0], i_y};
  end

  assign x_s = x_sync[SYNC_N-1];
  assign y_s = y_sync[SYNC_N-1];

  // Counters with this cycle's sample added
  always_comb begin
    cnt_d.cnt_x  = cnt_q.cnt_x + CNT_W'(x_s);
    cnt_d.cnt_y  = cnt_q.cnt_y + CNT_W'(y_s);
    cnt_d.cnt_xy = cnt_q.cnt_xy + CNT_W'(x_s & y_s);
  end

  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst) begin
      running_q <= 1'b0;
      done_q    <= 1'b0;
      idx_q     <= '0;
      cnt_q     <= '0;
      result_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (i_start) begin
        running_q <= 1'b1;  // First sample next cycle
        idx_q     <= '0;
        cnt_q     <= '0;
      end else if (running_q) begin
        cnt_q <= cnt_d;
        idx_q <= idx_q + 1'b1;
        if (idx_q == LAST_IDX) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
          result_q  <= cnt_d;  // Includes the last sample
        end
      end
    end
  end

  assign o_done   = done_q;
  assign o_counts = result_q;

  // Coincidences can never outnumber either single count
  a_xy_bounded: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    (o_counts.cnt_xy <= o_counts.cnt_x) && (o_counts.cnt_xy <= o_counts.cnt_y));

endmodule

//--- logic/resp_serializer.sv
`timescale 1ns/1ps

module resp_serializer import corr_pkg::*; (
  input  logic         i_clk_48MHz,
  input  logic         i_rst,
  input  logic         i_load,
  input  corr_counts_t i_counts,
  output logic         o_busy,
  output bp_beat_t     o_bp_out,
  input  logic         i_bp_out_ready
);

  localparam int REC_W   = $bits(corr_counts_t);
  localparam int N_BYTES = REC_W / 8;
  localparam int IDX_W   = $clog2(N_BYTES);
  localparam logic [IDX_W-1:0] LAST_BYTE = IDX_W'(N_BYTES - 1);

  logic [REC_W-1:0] shift_q;     // Current byte in the top bits
  logic [IDX_W-1:0] byte_idx_q;
  logic             valid_q;
  logic             xfer;

  assign xfer = valid_q && i_bp_out_ready;

  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst) begin
      valid_q    <= 1'b0;
      byte_idx_q <= '0;
    end else if (i_load) begin
      valid_q    <= 1'b1;
      byte_idx_q <= '0;
    end else if (xfer) begin
      byte_idx_q <= byte_idx_q + 1'b1;
      if (byte_idx_q == LAST_BYTE) begin
        valid_q <= 1'b0;  // Sixth byte gone
      end
    end
  end

  always_ff @(posedge i_clk_48MHz) begin
    if (i_load) begin
      shift_q <= i_counts;
    end else if (xfer) begin
      shift_q <= {shift_q[REC_W-9:0], 8'h00};  // Next byte up
    end
  end

  assign o_bp_out.data  = shift_q[REC_W-1 -: 8];
  assign o_bp_out.valid = valid_q;
  assign o_busy         = valid_q;

  // Stalled byte must hold, relies on no load while busy
  a_hold_on_stall: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    (o_bp_out.valid && !i_bp_out_ready) |=>
      (o_bp_out.valid && $stable(o_bp_out.data)));

endmodule

//--- logic/led_pwm.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module led_pwm (
  input  logic                   i_clk_48MHz,
  input  logic                   i_rst,
  input  logic [`CORR_PWM_W-1:0] i_duty,
  output logic                   o_led
);

  logic [`CORR_PWM_W-1:0] cnt_q;
  logic [`CORR_PWM_W-1:0] duty_q;  // Duty for the current period

  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst) begin
      cnt_q  <= '0;
      duty_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == '1) begin
        duty_q <= i_duty;  // Pick up new duty at wrap
      end
    end
  end

  // High for duty_q counts of each period
  assign o_led = (cnt_q < duty_q);

endmodule

//--- logic/corr_ctrl.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_ctrl import corr_pkg::*; (
  input  logic                   i_clk_48MHz,
  input  logic                   i_rst,
  input  bp_beat_t               i_bp_in,
  output logic                   o_bp_in_ready,
  output logic                   o_start,
  input  logic                   i_done,
  output logic                   o_load,
  input  logic                   i_busy,
  output logic [`CORR_PWM_W-1:0] o_duty
);

  corr_state_e            state_q;
  corr_state_e            state_d;
  logic                   in_ready_q;
  logic                   start_q;
  logic                   start_d;
  logic                   load_q;
  logic                   load_d;
  logic                   win_run_q;  // Window in flight in the accumulator
  logic [`CORR_PWM_W-1:0] duty_q;
  logic [`CORR_PWM_W-1:0] duty_d;
  logic                   xfer;

  assign xfer = i_bp_in.valid && in_ready_q;

  always_comb begin
    state_d = state_q;
    start_d = 1'b0;
    load_d  = 1'b0;
    duty_d  = duty_q;
    case (state_q)
      IDLE: begin
        if (xfer) begin
          case (i_bp_in.data)
            `CORR_CMD_START: begin
              start_d = !win_run_q && !start_q;  // Ignore while running
            end
            `CORR_CMD_LED: begin
              state_d = GET_DUTY;
            end
            `CORR_CMD_READ: begin
              load_d  = 1'b1;
              state_d = WAIT_SER;
            end
            default: begin
              state_d = IDLE;  // Unknown byte dropped
            end
          endcase
        end
      end
      GET_DUTY: begin
        if (xfer) begin
          duty_d  = i_bp_in.data[`CORR_PWM_W-1:0];
          state_d = IDLE;
        end
      end
      WAIT_SER: begin
        // Busy is still low in the load cycle itself
        if (!load_q && !i_busy) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk_48MHz) begin
    if (i_rst) begin
      state_q    <= IDLE;
      in_ready_q <= 1'b0;
      start_q    <= 1'b0;
      load_q     <= 1'b0;
      win_run_q  <= 1'b0;
      duty_q     <= '0;
    end else begin
      state_q    <= state_d;
      in_ready_q <= (state_d != WAIT_SER);  // Off while readout streams
      start_q    <= start_d;
      load_q     <= load_d;
      duty_q     <= duty_d;
      if (start_q) begin
        win_run_q <= 1'b1;
      end else if (i_done) begin
        win_run_q <= 1'b0;
      end
    end
  end

  assign o_bp_in_ready = in_ready_q;
  assign o_start       = start_q;
  assign o_load        = load_q;
  assign o_duty        = duty_q;

  // Serializer must be idle when a new readout is loaded
  a_load_idle: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    o_load |-> !i_busy);

  // No restart before the accumulator reports done
  a_start_idle: assert property (@(posedge i_clk_48MHz) disable iff (i_rst)
    o_start |-> !win_run_q);

endmodule

//--- logic/corr_top.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_top import corr_pkg::*; (
  input  logic     i_clk_48MHz,
  input  logic     i_rst,
  input  logic     i_x,             // Async X probe
  input  logic     i_y,             // Async Y probe
  input  bp_beat_t i_bp_in,         // Host to device
  output logic     o_bp_in_ready,
  output bp_beat_t o_bp_out,        // Device to host
  input  logic     i_bp_out_ready,
  output logic     o_led
);

  logic                   start;
  logic                   done;
  logic                   load;
  logic                   busy;
  logic [`CORR_PWM_W-1:0] duty;
  corr_counts_t           counts;

  corr_ctrl u_ctrl (
    .i_clk_48MHz   (i_clk_48MHz),
    .i_rst         (i_rst),
    .i_bp_in       (i_bp_in),
    .o_bp_in_ready (o_bp_in_ready),
    .o_start       (start),
    .i_done        (done),
    .o_load        (load),
    .i_busy        (busy),
    .o_duty        (duty)
  );

  corr_accum u_accum (
    .i_clk_48MHz (i_clk_48MHz),
    .i_rst       (i_rst),
    .i_x         (i_x),
    .i_y         (i_y),
    .i_start     (start),
    .o_done      (done),
    .o_counts    (counts)
  );

  // Reads the accumulator result record directly
  resp_serializer u_ser (
    .i_clk_48MHz    (i_clk_48MHz),
    .i_rst          (i_rst),
    .i_load         (load),
    .i_counts       (counts),
    .o_busy         (busy),
    .o_bp_out       (o_bp_out),
    .i_bp_out_ready (i_bp_out_ready)
  );

  led_pwm u_pwm (
    .i_clk_48MHz (i_clk_48MHz),
    .i_rst       (i_rst),
    .i_duty      (duty),
    .o_led       (o_led)
  );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic o_clk_48MHz,
  output logic o_rst
);

  localparam int RST_CYCLES = 8;

  initial begin
    o_clk_48MHz = 1'b0;
    forever #10 o_clk_48MHz = ~o_clk_48MHz;  // 20 ns period
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk_48MHz);
    @(negedge o_clk_48MHz);  // Release away from the active edge
    o_rst = 1'b0;
  end

endmodule

//--- tb/corr_checker.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module corr_checker import corr_pkg::*; (
  input  logic     i_clk_48MHz,
  input  logic     i_rst,
  input  logic     i_bp_in_ready,
  input  bp_beat_t i_bp_out,
  input  logic     i_bp_out_ready,
  input  logic     i_led
);

  localparam int REC_W   = $bits(corr_counts_t);
  localparam int N_BYTES = REC_W / 8;
  localparam int PERIOD  = 1 << `CORR_PWM_W;

  logic [7:0]        rx_q[$];   // Response bytes in arrival order
  logic [PERIOD-1:0] led_hist;  // Last full PWM period of LED samples
  int                n_pass   = 0;
  int                n_fail   = 0;
  int                n_checks = 0;
  int                n_errors = 0;
  int                err_mark = 0;

  always @(posedge i_clk_48MHz) begin
    led_hist <= {led_hist[PERIOD-2:0], i_led};
    if (!i_rst && i_bp_out.valid && i_bp_out_ready) begin
      rx_q.push_back(i_bp_out.data);  // Byte moves on this edge
    end
    if (!i_rst && i_bp_out.valid && i_bp_in_ready) begin
      report_failure("Input ready was high while a readout streamed");
    end
  end

  function automatic int rx_count();
    return rx_q.size();
  endfunction

  function automatic int error_count();
    return n_errors;
  endfunction

  function automatic void compare_value(string name, string field, int exp, int act);
    n_checks++;
    if (exp != act) begin
      n_errors++;
      $display("Error test %s %s expected %0d actual %0d", name, field, exp, act);
    end
  endfunction

  function automatic void report_failure(string msg);
    n_errors++;
    $display("%s", msg);
  endfunction

  function automatic void report_missing(string name, int got, corr_state_e st);
    report_failure($sformatf("Readout for %s stopped after %0d of %0d bytes, controller in %s",
      name, got, N_BYTES, st.name()));
    rx_q.delete();
  endfunction

  // Rebuild the record MSB first and compare field by field
  function automatic void compare_counts(string name, corr_counts_t exp);
    logic [REC_W-1:0] rec;
    corr_counts_t     got;
    int               i;
    if (rx_q.size() != N_BYTES) begin
      report_failure($sformatf("Readout for %s brought %0d bytes instead of %0d",
        name, rx_q.size(), N_BYTES));
      rx_q.delete();
      return;
    end
    rec = '0;
    for (i = 0; i < N_BYTES; i++) begin
      rec = {rec[REC_W-9:0], rx_q.pop_front()};
    end
    got = rec;
    compare_value(name, "cnt_x", int'(exp.cnt_x), int'(got.cnt_x));
    compare_value(name, "cnt_y", int'(exp.cnt_y), int'(got.cnt_y));
    compare_value(name, "cnt_xy", int'(exp.cnt_xy), int'(got.cnt_xy));
  endfunction

  // Any full period of a steady duty holds exactly duty high samples
  function automatic void compare_led(string name, int duty);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < PERIOD; i++) begin
      if (led_hist[i]) begin
        ones++;
      end
    end
    compare_value(name, "led_high", duty, ones);
  endfunction

  function automatic void end_test(string name);
    if (n_errors == err_mark) begin
      n_pass++;
      $display("Passed test %s", name);
    end else begin
      n_fail++;
      $display("Failed test %s with %0d errors", name, n_errors - err_mark);
    end
    err_mark = n_errors;
  endfunction

  function automatic void summary();
    $display("Tests passed %0d failed %0d, checks %0d, errors %0d",
      n_pass, n_fail, n_checks, n_errors);
  endfunction

endmodule

//--- tb/tb_corr_top.sv
`timescale 1ns/1ps
`include "corr_macros.svh"

module tb_corr_top import corr_pkg::*; ();

  localparam int WIN         = `CORR_WINDOW_LEN;
  localparam int CNT_W       = `CORR_CNT_W;
  localparam int PERIOD      = 1 << `CORR_PWM_W;
  localparam int N_ENTRIES   = 7;
  localparam int CYCLE_LIMIT = (N_ENTRIES + 1) * (WIN + 600);  // Entries plus first read
  localparam int READ_LIMIT  = 200;
  localparam int MID_SAMPLE  = 100;  // Where the mid window commands go in
  localparam int PAT_LOW  = 0;
  localparam int PAT_HIGH = 1;
  localparam int PAT_TOG  = 2;  // High on even samples
  localparam int PAT_TOGN = 3;  // High on odd samples
  localparam int PAT_RAND = 4;

  typedef struct packed {
    int           x_pat;
    int           y_pat;
    bit           stall;  // Random back-pressure on readout
    bit           mid;    // Read and restart while the window runs
    bit           led;
    int           duty;
    corr_counts_t exp;
  } test_t;

  logic         clk_48MHz;
  logic         rst;
  logic         x;
  logic         y;
  logic         bp_in_ready;
  logic         bp_out_ready;
  logic         led;
  bp_beat_t     bp_in;
  bp_beat_t     bp_out;
  string        test_name[$];
  test_t        test_tab[$];
  logic [7:0]   host_q[$];       // Bytes waiting for the host pipe
  logic         x_smp[WIN];
  logic         y_smp[WIN];
  int           smp_idx = WIN;   // Next probe sample, WIN when idle
  int           cycles = 0;
  bit           arm_window = 1'b0;
  bit           beat_sent = 1'b0;
  bit           done_seen = 1'b0;
  bit           stall_en = 1'b0;
  corr_counts_t prev_exp;

  tb_clock i_clock (.o_clk_48MHz(clk_48MHz), .o_rst(rst));

  corr_top i_corr_top (
    .i_clk_48MHz    (clk_48MHz),
    .i_rst          (rst),
    .i_x            (x),
    .i_y            (y),
    .i_bp_in        (bp_in),
    .o_bp_in_ready  (bp_in_ready),
    .o_bp_out       (bp_out),
    .i_bp_out_ready (bp_out_ready),
    .o_led          (led)
  );

  corr_checker i_checker (
    .i_clk_48MHz    (clk_48MHz),
    .i_rst          (rst),
    .i_bp_in_ready  (bp_in_ready),
    .i_bp_out       (bp_out),
    .i_bp_out_ready (bp_out_ready),
    .i_led          (led)
  );

  function automatic void add_test(string name, int xp, int yp, bit stall, bit mid,
                                   bit led_on, int duty, int ex, int ey, int exy);
    test_t tc;
    tc.x_pat = xp;
    tc.y_pat = yp;
    tc.stall = stall;
    tc.mid   = mid;
    tc.led   = led_on;
    tc.duty  = duty;
    tc.exp   = {CNT_W'(ex), CNT_W'(ey), CNT_W'(exy)};
    test_name.push_back(name);
    test_tab.push_back(tc);
  endfunction

  function automatic logic sample_bit(int pat, int k);
    case (pat)
      PAT_HIGH: return 1'b1;
      PAT_TOG:  return (k % 2) == 0;
      PAT_TOGN: return (k % 2) == 1;
      PAT_RAND: return 1'($urandom % 2);
      default:  return 1'b0;
    endcase
  endfunction

  // One falling edge: host byte, probe sample and readout ready
  task automatic tick();
    @(negedge clk_48MHz);
    if (beat_sent) begin
      void'(host_q.pop_front());  // Moved on the last rising edge
    end
    beat_sent = 1'b0;
    if (host_q.size() > 0) begin
      bp_in.data  = host_q[0];
      bp_in.valid = 1'b1;
      beat_sent   = bp_in_ready;
      if (arm_window && beat_sent && host_q[0] == `CORR_CMD_START) begin
        arm_window = 1'b0;
        smp_idx    = 0;  // Sample 0 meets the start byte edge
      end
    end else begin
      bp_in.valid = 1'b0;
    end
    if (smp_idx < WIN) begin
      x = x_smp[smp_idx];
      y = y_smp[smp_idx];
      smp_idx++;
    end else begin
      x = 1'b1;  // High outside the window, must not be counted
      y = 1'b1;
    end
    bp_out_ready = stall_en ? (($urandom % 3) != 0) : 1'b1;
    if (i_corr_top.done) begin
      done_seen = 1'b1;
    end
  endtask

  // Readout ends when the controller takes bytes again
  task automatic wait_bytes(string name, corr_counts_t exp);
    int n;
    n = 0;
    while ((i_checker.rx_count() < 6 || !bp_in_ready) && n < READ_LIMIT) begin
      tick();
      n++;
    end
    if (i_checker.rx_count() < 6) begin
      i_checker.report_missing(name, i_checker.rx_count(), i_corr_top.u_ctrl.state_q);
    end else if (!bp_in_ready) begin
      i_checker.report_failure($sformatf("Input ready stayed low after the readout of %s",
        name));
    end else begin
      i_checker.compare_counts(name, exp);
    end
  endtask

  task automatic run_test(string name, test_t tc);
    corr_counts_t exp;
    bit           tally;
    int           k;
    tally = (tc.x_pat == PAT_RAND) || (tc.y_pat == PAT_RAND);
    exp   = tally ? '0 : tc.exp;
    for (k = 0; k < WIN; k++) begin
      x_smp[k] = sample_bit(tc.x_pat, k);
      y_smp[k] = sample_bit(tc.y_pat, k);
      if (tally) begin
        exp.cnt_x  += CNT_W'(x_smp[k]);
        exp.cnt_y  += CNT_W'(y_smp[k]);
        exp.cnt_xy += CNT_W'(x_smp[k] & y_smp[k]);
      end
    end
    stall_en   = tc.stall;
    done_seen  = 1'b0;
    arm_window = 1'b1;
    host_q.push_back(`CORR_CMD_START);
    if (tc.mid) begin
      while (arm_window || smp_idx < MID_SAMPLE) begin
        tick();
      end
      host_q.push_back(`CORR_CMD_READ);
      host_q.push_back(`CORR_CMD_START);  // Must be ignored
      wait_bytes({name, "_mid_read"}, prev_exp);
    end
    k = 0;
    while (!done_seen && k < WIN + 50) begin
      tick();
      k++;
    end
    if (!done_seen) begin
      i_checker.report_failure($sformatf("No done pulse from the window of test %s", name));
    end
    host_q.push_back(`CORR_CMD_READ);
    wait_bytes(name, exp);
    if (tc.led) begin
      host_q.push_back(`CORR_CMD_LED);
      host_q.push_back(8'(tc.duty));
      while (host_q.size() > 0) begin
        tick();
      end
      repeat (PERIOD + 4 + PERIOD) tick();  // Next wrap, then one full period
      i_checker.compare_led(name, tc.duty);
      repeat (PERIOD) tick();
      i_checker.compare_led(name, tc.duty);
    end
    stall_en = 1'b0;
    prev_exp = exp;
    i_checker.end_test(name);
  endtask

  always @(posedge clk_48MHz) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped by the cycle limit of %0d", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    x            = 1'b0;
    y            = 1'b0;
    bp_in        = '0;
    bp_out_ready = 1'b1;
    void'($urandom(32'hb2da5957));
    //        name               x pattern  y pattern  stall mid led duty  x     y     xy
    add_test("all_low",          PAT_LOW,  PAT_LOW,  0, 0, 0, 0,   0,    0,    0);
    add_test("x_high_y_low",     PAT_HIGH, PAT_LOW,  0, 0, 1, 255, 1000, 0,    0);
    add_test("both_high",        PAT_HIGH, PAT_HIGH, 1, 0, 0, 0,   1000, 1000, 1000);
    add_test("xy_toggle",        PAT_TOG,  PAT_TOG,  1, 0, 1, 64,  500,  500,  500);
    add_test("xy_antiphase",     PAT_TOG,  PAT_TOGN, 0, 0, 0, 0,   500,  500,  0);
    add_test("x_high_y_toggle",  PAT_HIGH, PAT_TOG,  1, 1, 1, 0,   1000, 500,  500);
    add_test("random",           PAT_RAND, PAT_RAND, 1, 0, 0, 0,   0,    0,    0);
    wait (!rst);
    while (!bp_in_ready) begin
      tick();
    end
    prev_exp = '0;
    host_q.push_back(`CORR_CMD_READ);  // Nothing counted yet
    wait_bytes("read_before_window", prev_exp);
    i_checker.end_test("read_before_window");
    for (int t = 0; t < test_tab.size(); t++) begin
      run_test(test_name[t], test_tab[t]);
    end
    i_checker.summary();
    if (i_checker.error_count() == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+logic
logic/corr_pkg.sv
logic/corr_accum.sv
logic/resp_serializer.sv
logic/led_pwm.sv
logic/corr_ctrl.sv
logic/corr_top.sv
tb/tb_clock.sv
tb/corr_checker.sv
tb/tb_corr_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the correlator testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 --top-module tb_corr_top \
  -f build.f -o sim_corr > "$LOG" 2>&1 &&
  ./obj_dir/sim_corr >> "$LOG" 2>&1 ||
  echo "Test FAILED" >> "$LOG"

cat "$LOG"

grep -q "Test FAILED" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
